// File: armleocpu_execute.f
common/riscv_isa_pkg.sv
common/alu_pkg.sv
alu/armleocpu_alu.sv
hdl/armleocpu_decode.sv
hdl/armleocpu_regfile.sv
hdl/armleocpu_execute.sv
dv/armleocpu_execute_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute slice testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module armleocpu_execute_tb \
	-f armleocpu_execute.f \
	-o armleocpu_execute_sim

sim_out=$(./obj_dir/armleocpu_execute_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "No errors"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: dv/armleocpu_execute_tb.sv
`timescale 1ns/1ps

module armleocpu_execute_tb;
	import riscv_isa_pkg::*;
	import alu_pkg::*;

	localparam int NUM_INSTR      = 2000;
	localparam int RESET_CYCLES   = 8;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_INSTR + 64; // gaps of up to 1 cycle.

	logic      clk;
	logic      arst_n;
	logic      issue_valid;
	instr_t    issue_instr;
	logic      retire_valid;
	reg_addr_t retire_rd;
	word_t     retire_result;
	logic      retire_illegal;

	logic [31:0] lfsr_state;
	int          cycle_count;
	int          step_count;
	int          issued;
	reg_addr_t   last_rd;
	word_t       model_regs [32];

	// expected retires, oldest first.
	reg_addr_t exp_rd_q [$];
	word_t     exp_result_q [$];
	logic      exp_illegal_q [$];
	int        exp_due_q [$];

	armleocpu_execute i_dut (
		.clk            (clk),
		.arst_n         (arst_n),
		.issue_valid    (issue_valid),
		.issue_instr    (issue_instr),
		.retire_valid   (retire_valid),
		.retire_rd      (retire_rd),
		.retire_result  (retire_result),
		.retire_illegal (retire_illegal)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure($sformatf("timeout after %0d cycles", cycle_count));
	end

	// ==============================
	// reporting
	// ==============================
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
			report_failure("retire value mismatch");
		end
	endtask

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			report_failure("retire value mismatch");
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
			report_failure("retire value mismatch");
		end
	endtask

	// ==============================
	// random source
	// ==============================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003; // taps 32 22 2 1.
		return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic reg_addr_t rand_reg();
		if (rand_bits(3) == 32'd0)
			return 5'd0; // x0 more often.
		return 5'(rand_bits(5));
	endfunction

	function automatic instr_t r_type_word(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		instr_t ins;
		ins.rtype.funct7 = f7;
		ins.rtype.rs2    = rs2;
		ins.rtype.rs1    = rs1;
		ins.rtype.funct3 = f3;
		ins.rtype.rd     = rd;
		ins.rtype.opcode = OPCODE_OP;
		return ins;
	endfunction

	function automatic instr_t i_type_word(input logic [11:0] imm, input reg_addr_t rs1,
			input logic [2:0] f3, input reg_addr_t rd);
		instr_t ins;
		ins.itype.imm12  = imm;
		ins.itype.rs1    = rs1;
		ins.itype.funct3 = f3;
		ins.itype.rd     = rd;
		ins.itype.opcode = OPCODE_OP_IMM;
		return ins;
	endfunction

	// ==============================
	// reference model
	// ==============================
	function automatic word_t model_alu(input logic is_imm, input logic [6:0] f7,
			input logic [2:0] f3, input word_t a, input word_t b, output logic unknown);
		logic [6:0]  f7_eff;
		alu_op_t     code;
		logic [63:0] prod;
		word_t       res;
		f7_eff  = (is_imm && f3 != 3'b001 && f3 != 3'b101) ? 7'h00 : f7;
		code    = {f7_eff, f3};
		unknown = 1'b0;
		res     = a + b;
		prod    = '0;
		case (code)
			ALU_OP_ADD:  res = a + b;
			ALU_OP_SUB:  res = a - b;
			ALU_OP_SLL:  res = a << b[4:0];
			ALU_OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
			ALU_OP_XOR:  res = a ^ b;
			ALU_OP_SRL:  res = a >> b[4:0];
			ALU_OP_SRA:  res = $signed(a) >>> b[4:0];
			ALU_OP_OR:   res = a | b;
			ALU_OP_AND:  res = a & b;
			ALU_OP_MUL: begin
				prod = {32'h0, a} * {32'h0, b};
				res  = prod[31:0];
			end
			ALU_OP_MULH: begin
				prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
				res  = prod[63:32];
			end
			ALU_OP_MULHSU: begin
				prod = {{32{a[31]}}, a} * {32'h0, b};
				res  = prod[63:32];
			end
			ALU_OP_MULHU: begin
				prod = {32'h0, a} * {32'h0, b};
				res  = prod[63:32];
			end
			ALU_OP_DIV: begin
				if (b == '0)
					res = '1;
				else if (a == 32'h8000_0000 && b == 32'hffff_ffff)
					res = 32'h8000_0000; // signed overflow.
				else
					res = $signed(a) / $signed(b);
			end
			ALU_OP_DIVU: res = (b == '0) ? '1 : a / b;
			ALU_OP_REM: begin
				if (b == '0)
					res = a;
				else if (a == 32'h8000_0000 && b == 32'hffff_ffff)
					res = '0;
				else
					res = $signed(a) % $signed(b);
			end
			ALU_OP_REMU: res = (b == '0) ? a : a % b;
			default: unknown = 1'b1;
		endcase
		return res;
	endfunction

	task automatic model_issue(input instr_t ins, input int due);
		logic  is_op;
		logic  is_imm;
		word_t a;
		word_t b;
		word_t res;
		logic  unknown;
		logic  illegal;
		is_op  = (ins.rtype.opcode == OPCODE_OP);
		is_imm = (ins.rtype.opcode == OPCODE_OP_IMM);
		a      = model_regs[ins.rtype.rs1];
		b      = is_imm ? {{20{ins.itype.imm12[11]}}, ins.itype.imm12} :
			model_regs[ins.rtype.rs2];
		res     = model_alu(is_imm, ins.rtype.funct7, ins.rtype.funct3, a, b, unknown);
		illegal = !(is_op || is_imm) || unknown;
		if (!illegal && ins.rtype.rd != 5'd0)
			model_regs[ins.rtype.rd] = res;
		exp_rd_q.push_back(ins.rtype.rd);
		exp_result_q.push_back(res);
		exp_illegal_q.push_back(illegal);
		exp_due_q.push_back(due);
	endtask

	task automatic check_retire();
		logic due_now;
		due_now = (exp_due_q.size() > 0) && (exp_due_q[0] == step_count);
		if (retire_valid === 1'b1) begin
			if (!due_now)
				report_failure("retire_valid went high with no instruction due");
			compare_addr("retire_rd", exp_rd_q[0], retire_rd);
			compare_word("retire_result", exp_result_q[0], retire_result);
			compare_bit("retire_illegal", exp_illegal_q[0], retire_illegal);
			void'(exp_rd_q.pop_front());
			void'(exp_result_q.pop_front());
			void'(exp_illegal_q.pop_front());
			void'(exp_due_q.pop_front());
		end else if (due_now) begin
			report_failure("retire_valid stayed low while a retire was due");
		end
	endtask

	// ==============================
	// stimulus
	// ==============================
	// one cycle, retire shows up two steps after the drive.
	task automatic step(input logic valid, input instr_t ins);
		@(posedge clk);
		#2;
		step_count++;
		check_retire();
		issue_valid = valid;
		issue_instr = ins;
		if (valid) begin
			model_issue(ins, step_count + 2);
			issued++;
		end
	endtask

	task automatic issue(input instr_t ins);
		if (rand_bits(1) != 0)
			step(1'b0, rand_bits(32)); // idle, junk on the bus.
		step(1'b1, ins);
		last_rd = ins.rtype.rd;
	endtask

	task automatic preload_regs();
		reg_addr_t rd;
		for (int r = 1; r < 32; r++) begin
			rd = 5'(r);
			issue(i_type_word(12'(rand_bits(12)), 5'd0, 3'b000, rd));
			issue(i_type_word(12'd10, rd, FUNCT3_SLL, rd));
			issue(i_type_word(12'(rand_bits(12)), rd, 3'b100, rd));
			issue(i_type_word(12'd11, rd, FUNCT3_SLL, rd));
			issue(i_type_word(12'(rand_bits(12)), rd, 3'b100, rd));
		end
	endtask

	task automatic op_imm_instr();
		logic [2:0]  f3;
		logic [11:0] imm;
		f3  = 3'(rand_bits(3));
		imm = 12'(rand_bits(12));
		if (f3 == FUNCT3_SLL)
			imm[11:5] = 7'h00;
		else if (f3 == FUNCT3_SR)
			imm[11:5] = (rand_bits(1) != 0) ? FUNCT7_ALT : 7'h00; // bit 30 picks srai.
		issue(i_type_word(imm, rand_reg(), f3, rand_reg()));
	endtask

	task automatic reg_reg_instr();
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = 3'(rand_bits(3));
		f7 = 7'h00;
		if ((f3 == 3'b000 || f3 == FUNCT3_SR) && rand_bits(1) != 0)
			f7 = FUNCT7_ALT;
		issue(r_type_word(f7, rand_reg(), rand_reg(), f3, rand_reg()));
	endtask

	task automatic muldiv_instr();
		logic [2:0] f3;
		logic [1:0] kind;
		reg_addr_t  ra;
		reg_addr_t  rb;
		f3   = 3'(rand_bits(3));
		kind = 2'(rand_bits(2));
		if (f3[2] && kind == 2'd0) begin
			issue(r_type_word(FUNCT7_MULDIV, 5'd0, rand_reg(), f3, rand_reg())); // by zero.
		end else if (f3[2] && kind == 2'd1) begin
			ra = 5'd1 + 5'(rand_bits(3));
			rb = 5'd9 + 5'(rand_bits(3));
			issue(i_type_word(12'd1, 5'd0, 3'b000, ra));
			issue(i_type_word(12'd31, ra, FUNCT3_SLL, ra)); // most negative.
			issue(i_type_word(12'hfff, 5'd0, 3'b000, rb)); // minus one.
			issue(r_type_word(FUNCT7_MULDIV, rb, ra, f3, rand_reg()));
		end else begin
			issue(r_type_word(FUNCT7_MULDIV, rand_reg(), rand_reg(), f3, rand_reg()));
		end
	endtask

	task automatic illegal_instr();
		instr_t     ins;
		logic [1:0] kind;
		ins  = rand_bits(32);
		kind = 2'(rand_bits(2));
		case (kind)
			2'd0: begin
				if (ins.rtype.opcode == OPCODE_OP || ins.rtype.opcode == OPCODE_OP_IMM)
					ins.rtype.opcode = 7'b0000011; // load.
			end
			2'd1: begin
				ins.rtype.opcode = OPCODE_OP;
				if (ins.rtype.funct7 == 7'h00 || ins.rtype.funct7 == FUNCT7_ALT ||
						ins.rtype.funct7 == FUNCT7_MULDIV)
					ins.rtype.funct7 = 7'b1000000;
			end
			2'd2: begin
				ins.itype.opcode = OPCODE_OP_IMM;
				ins.itype.funct3 = FUNCT3_SLL;
				if (ins.rtype.funct7 == 7'h00)
					ins.rtype.funct7 = FUNCT7_ALT;
			end
			default: begin
				ins.itype.opcode = OPCODE_OP_IMM;
				ins.itype.funct3 = FUNCT3_SR;
				if (ins.rtype.funct7 == 7'h00 || ins.rtype.funct7 == FUNCT7_ALT)
					ins.rtype.funct7 = 7'b0100001;
			end
		endcase
		issue(ins);
		// read the target back, it must be untouched.
		issue(r_type_word(7'h00, 5'd0, ins.rtype.rd, 3'b000, rand_reg()));
	endtask

	task automatic dependent_instr();
		issue(i_type_word(12'(rand_bits(12)), last_rd, 3'b000, rand_reg()));
		issue(r_type_word(7'h00, last_rd, last_rd, 3'b000, rand_reg()));
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		issue_valid = 1'b0;
		issue_instr = '0;
		lfsr_state  = 32'hc1c4_964b;
		cycle_count = 0;
		step_count  = 0;
		issued      = 0;
		last_rd     = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		arst_n = 1'b1;
		preload_regs();
		while (issued < NUM_INSTR) begin
			case (3'(rand_bits(3)))
				3'd0, 3'd1: op_imm_instr();
				3'd2, 3'd3: reg_reg_instr();
				3'd4, 3'd5: muldiv_instr();
				3'd6:       illegal_instr();
				default:    dependent_instr();
			endcase
		end
		repeat (3) step(1'b0, '0); // drain.
		if (exp_rd_q.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			report_failure("instructions still waiting to retire at the end of the run");
		end
	end

endmodule

// File: hdl/armleocpu_execute.sv
`timescale 1ns/1ps

module armleocpu_execute (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     issue_valid,
	input  riscv_isa_pkg::instr_t    issue_instr,
	output logic                     retire_valid,
	output riscv_isa_pkg::reg_addr_t retire_rd,
	output alu_pkg::word_t           retire_result,
	output logic                     retire_illegal
);
	import riscv_isa_pkg::*;
	import alu_pkg::*;

	logic       instr_valid;
	instr_t     instr_q;
	reg_addr_t  rs1_addr;
	reg_addr_t  rs2_addr;
	reg_addr_t  rd;
	logic       is_alui;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm;
	logic       illegal_opcode;
	word_t      rs1_data;
	word_t      rs2_data;
	word_t      alu_result;
	logic       unknown_operation;
	logic       illegal;
	logic       wr_en;

	// ==============================
	// issue register
	// ==============================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			instr_valid <= 1'b0;
			instr_q     <= '0;
		end else begin
			instr_valid <= issue_valid;
			if (issue_valid)
				instr_q <= issue_instr;
		end
	end

	armleocpu_decode i_decode (
		.instr          (instr_q),
		.rs1_addr       (rs1_addr),
		.rs2_addr       (rs2_addr),
		.rd             (rd),
		.is_alui        (is_alui),
		.funct3         (funct3),
		.funct7         (funct7),
		.imm            (imm),
		.illegal_opcode (illegal_opcode)
	);

	armleocpu_regfile i_regfile (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wr_en),
		.wr_addr  (rd),
		.wr_data  (alu_result)
	);

	armleocpu_alu i_alu (
		.is_alui           (is_alui),
		.funct3            (funct3),
		.funct7            (funct7),
		.operand0          (rs1_data),
		.alu_operand1      (rs2_data),
		.alui_operand1     (imm),
		.result            (alu_result),
		.unknown_operation (unknown_operation)
	);

	// bad opcode or bad function code.
	assign illegal = illegal_opcode | unknown_operation;
	assign wr_en   = instr_valid & ~illegal; // write lands with the retire edge.

	// ==============================
	// retire registers
	// ==============================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retire_valid   <= 1'b0;
			retire_rd      <= '0;
			retire_result  <= '0;
			retire_illegal <= 1'b0;
		end else begin
			retire_valid <= instr_valid;
			if (instr_valid) begin
				retire_rd      <= rd;
				retire_result  <= alu_result;
				retire_illegal <= illegal;
			end
		end
	end

endmodule

// File: hdl/armleocpu_regfile.sv
`timescale 1ns/1ps

module armleocpu_regfile (
	input  logic                     clk,
	input  logic                     arst_n,
	input  riscv_isa_pkg::reg_addr_t rs1_addr,
	input  riscv_isa_pkg::reg_addr_t rs2_addr,
	output alu_pkg::word_t           rs1_data,
	output alu_pkg::word_t           rs2_data,
	input  logic                     wr_en,
	input  riscv_isa_pkg::reg_addr_t wr_addr,
	input  alu_pkg::word_t           wr_data
);
	import alu_pkg::*;

	// x1 to x31 only.
	word_t regs [1:31];

	// ==============================
	// write port
	// ==============================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin // x0 writes dropped.
			regs[wr_addr] <= wr_data;
		end
	end

	// ==============================
	// read ports
	// ==============================
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: hdl/armleocpu_decode.sv
`timescale 1ns/1ps

module armleocpu_decode (
	input  riscv_isa_pkg::instr_t    instr,
	output riscv_isa_pkg::reg_addr_t rs1_addr,
	output riscv_isa_pkg::reg_addr_t rs2_addr,
	output riscv_isa_pkg::reg_addr_t rd,
	output logic                     is_alui,
	output logic [2:0]               funct3,
	output logic [6:0]               funct7,
	output alu_pkg::word_t           imm,
	output logic                     illegal_opcode
);
	import riscv_isa_pkg::*;
	import alu_pkg::*;

	opcode_t opcode;
	logic    is_op;
	logic    is_op_imm;

	// ==============================
	// register and function fields
	// ==============================
	// same bit positions in both formats.
	assign rs1_addr = instr.rtype.rs1;
	assign rs2_addr = instr.rtype.rs2;
	assign rd       = instr.rtype.rd;
	assign funct3   = instr.rtype.funct3;
	assign funct7   = instr.rtype.funct7; // shamt upper bits for immediates.

	// ==============================
	// immediate
	// ==============================
	assign imm = {{(XLEN-12){instr.itype.imm12[11]}}, instr.itype.imm12};

	// ==============================
	// opcode class
	// ==============================
	assign opcode    = instr.itype.opcode;
	assign is_op     = (opcode == OPCODE_OP);
	assign is_op_imm = (opcode == OPCODE_OP_IMM);

	assign is_alui = is_op_imm;

	// loads, stores, branches and system live elsewhere.
	assign illegal_opcode = !(is_op || is_op_imm);

endmodule

// File: alu/armleocpu_alu.sv
`timescale 1ns/1ps

module armleocpu_alu (
	input  logic           is_alui,
	input  logic [2:0]     funct3,
	input  logic [6:0]     funct7,
	input  alu_pkg::word_t operand0,
	input  alu_pkg::word_t alu_operand1,
	input  alu_pkg::word_t alui_operand1,
	output alu_pkg::word_t result,
	output logic           unknown_operation
);
	import alu_pkg::*;
	import riscv_isa_pkg::*;

	word_t              operand1;
	logic [6:0]         funct7_comb;
	alu_op_t            op;
	logic [4:0]         shamt;
	logic               muldiv_sel;
	logic               shr_fill;
	logic signed [32:0] shr_ext;
	logic               mul_a_sx;
	logic               mul_b_sx;
	logic signed [32:0] mul_a;
	logic signed [32:0] mul_b;
	logic signed [65:0] mul_full;
	logic               div_signed;
	logic               div_zero;
	logic signed [32:0] div_a;
	logic signed [32:0] div_b;
	logic signed [32:0] quot;
	logic signed [32:0] remd;

	assign operand1 = is_alui ? alui_operand1 : alu_operand1;

	// immediates carry no funct7 except the shifts.
	assign funct7_comb = (is_alui && funct3 != FUNCT3_SLL && funct3 != FUNCT3_SR) ?
		7'h0 : funct7;

	assign op         = {funct7_comb, funct3};
	assign shamt      = operand1[4:0];
	assign muldiv_sel = (funct7_comb == FUNCT7_MULDIV);

	// ==============================
	// shared right shifter
	// ==============================
	assign shr_fill = (funct7_comb == FUNCT7_ALT) & operand0[XLEN-1]; // sra only.
	assign shr_ext  = $signed({shr_fill, operand0}) >>> shamt;

	// ==============================
	// multiplier
	// ==============================
	// one 33x33 signed multiply covers all four variants.
	assign mul_a_sx = (funct3[1:0] != 2'b11) & operand0[XLEN-1]; // mulhu is unsigned.
	assign mul_b_sx = ~funct3[1] & operand1[XLEN-1];               // mul, mulh.
	assign mul_a    = muldiv_sel ? {mul_a_sx, operand0} : '0;
	assign mul_b    = muldiv_sel ? {mul_b_sx, operand1} : '0;
	assign mul_full = 66'(mul_a) * 66'(mul_b);

	// ==============================
	// divider
	// ==============================
	assign div_signed = ~funct3[0];
	assign div_zero   = (operand1 == '0);
	assign div_a      = muldiv_sel ? {div_signed & operand0[XLEN-1], operand0} : '0;

	// divisor parked at one when idle or zero.
	assign div_b = (muldiv_sel && !div_zero) ?
		{div_signed & operand1[XLEN-1], operand1} : 33'sd1;

	// min / -1 fits in 33 bits, so the low word is already min and the remainder zero.
	assign quot = div_a / div_b;
	assign remd = div_a % div_b;

	always_comb begin
		result            = operand0 + operand1;
		unknown_operation = 1'b0;
		case (op)
			ALU_OP_ADD:  result = operand0 + operand1;
			ALU_OP_SUB:  result = operand0 - operand1;
			ALU_OP_SLL:  result = operand0 << shamt;
			ALU_OP_SLT:  result = word_t'($signed(operand0) < $signed(operand1));
			ALU_OP_SLTU: result = word_t'(operand0 < operand1);
			ALU_OP_XOR:  result = operand0 ^ operand1;
			ALU_OP_SRL,
			ALU_OP_SRA:  result = shr_ext[XLEN-1:0];
			ALU_OP_OR:   result = operand0 | operand1;
			ALU_OP_AND:  result = operand0 & operand1;
			ALU_OP_MUL:  result = mul_full[XLEN-1:0];
			ALU_OP_MULH,
			ALU_OP_MULHSU,
			ALU_OP_MULHU: result = mul_full[2*XLEN-1:XLEN];
			ALU_OP_DIV,
			ALU_OP_DIVU: result = div_zero ? '1 : quot[XLEN-1:0];
			ALU_OP_REM,
			ALU_OP_REMU: result = div_zero ? operand0 : remd[XLEN-1:0];
			default: begin
				unknown_operation = 1'b1; // sum stays on result.
			end
		endcase
	end

endmodule

// File: common/alu_pkg.sv
package alu_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;

	// funct7 in the upper seven bits, funct3 below.
	typedef logic [9:0] alu_op_t;

	// ==============================
	// base integer ops
	// ==============================
	localparam alu_op_t ALU_OP_ADD    = 10'b0000000_000;
	localparam alu_op_t ALU_OP_SUB    = 10'b0100000_000;
	localparam alu_op_t ALU_OP_SLL    = 10'b0000000_001;
	localparam alu_op_t ALU_OP_SLT    = 10'b0000000_010;
	localparam alu_op_t ALU_OP_SLTU   = 10'b0000000_011;
	localparam alu_op_t ALU_OP_XOR    = 10'b0000000_100;
	localparam alu_op_t ALU_OP_SRL    = 10'b0000000_101;
	localparam alu_op_t ALU_OP_SRA    = 10'b0100000_101;
	localparam alu_op_t ALU_OP_OR     = 10'b0000000_110;
	localparam alu_op_t ALU_OP_AND    = 10'b0000000_111;

	// ==============================
	// m extension
	// ==============================
	localparam alu_op_t ALU_OP_MUL    = 10'b0000001_000;
	localparam alu_op_t ALU_OP_MULH   = 10'b0000001_001;
	localparam alu_op_t ALU_OP_MULHSU = 10'b0000001_010;
	localparam alu_op_t ALU_OP_MULHU  = 10'b0000001_011;
	localparam alu_op_t ALU_OP_DIV    = 10'b0000001_100;
	localparam alu_op_t ALU_OP_DIVU   = 10'b0000001_101;
	localparam alu_op_t ALU_OP_REM    = 10'b0000001_110;
	localparam alu_op_t ALU_OP_REMU   = 10'b0000001_111;

endpackage

// File: common/riscv_isa_pkg.sv
package riscv_isa_pkg;

	typedef logic [6:0] opcode_t;
	typedef logic [4:0] reg_addr_t;

	// ==============================
	// major opcodes
	// ==============================
	localparam opcode_t OPCODE_OP     = 7'b0110011; // register-register.
	localparam opcode_t OPCODE_OP_IMM = 7'b0010011; // register-immediate.

	// ==============================
	// function fields
	// ==============================
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub and sra.
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	// shift immediates keep their funct7.
	localparam logic [2:0] FUNCT3_SLL = 3'b001;
	localparam logic [2:0] FUNCT3_SR  = 3'b101;

	// one instruction word, two decodings.
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_addr_t  rs2;
			reg_addr_t  rs1;
			logic [2:0] funct3;
			reg_addr_t  rd;
			opcode_t    opcode;
		} rtype;
		struct packed {
			logic [11:0] imm12;
			reg_addr_t   rs1;
			logic [2:0]  funct3;
			reg_addr_t   rd;
			opcode_t     opcode;
		} itype;
	} instr_t;

endpackage
